// File: common/intra_config.svh
`ifndef INTRA_CONFIG_SVH
`define INTRA_CONFIG_SVH

// ============================================================
// block geometry
// ============================================================

// pixels in one 4x4 block
`define INTRA_BLOCK_PIXELS 16

// ============================================================
// prediction
// ============================================================

// flat dc value used for the first block of a frame
`define INTRA_DC_PRED 128

// ============================================================
// quantizer
// ============================================================

// largest qp the mf tables cover
`define INTRA_QP_MAX 29

// qbits at qp 0..5, one more per step of six
`define INTRA_QBITS_BASE 15

`endif

// File: common/intra_pkg.sv
`default_nettype none

package intra_pkg;

    // ============================================================
    // scalar types
    // ============================================================

    // input pixel, unsigned
    typedef logic        [7:0]  pixel_t;

    // pixel minus predictor
    typedef logic signed [8:0]  residual_t;

    // one transform output, 16 x 9 bit sum
    typedef logic signed [12:0] coef_t;

    // quantized level on the output port
    typedef logic signed [31:0] level_t;

    typedef logic        [4:0]  qp_t;

    // raster position inside a block, 4*row + col
    typedef logic        [3:0]  coef_idx_t;

    // ============================================================
    // stage payloads
    // ============================================================

    // collector to transform, whole block at once
    typedef struct packed {
        residual_t [15:0] res;
        qp_t              qp;
    } residual_block_t;

    // transform to quantizer, one coefficient per beat
    typedef struct packed {
        coef_t     value;
        coef_idx_t idx;
        qp_t       qp;
    } coef_beat_t;

endpackage

`default_nettype wire

// File: logic/block_collector.sv
`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module block_collector (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        in_valid,
    input  wire intra_pkg::pixel_t     pixel,
    input  wire intra_pkg::qp_t        qp,
    output logic                       block_valid,
    output intra_pkg::residual_block_t block
);

    // ============================================================
    // beat tracking
    // ============================================================

    intra_pkg::coef_idx_t beat_cnt;
    intra_pkg::residual_t res_in;
    logic                 first_beat;
    logic                 last_beat;

    // residual against the flat predictor
    assign res_in = intra_pkg::residual_t'(pixel) - intra_pkg::residual_t'(`INTRA_DC_PRED);

    assign first_beat = in_valid && (beat_cnt == '0);
    assign last_beat  = in_valid &&
                        (beat_cnt == intra_pkg::coef_idx_t'(`INTRA_BLOCK_PIXELS - 1));

    // counter holds through gaps in in_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (in_valid) begin
            // 4 bit counter wraps to 0 after beat 15
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // ============================================================
    // residual storage
    // ============================================================

    // the next block may overwrite entry 0 on the cycle after
    // block_valid, after the transform has already taken it
    always_ff @(posedge clk) begin
        if (in_valid) begin
            block.res[beat_cnt] <= res_in;
        end
        if (first_beat) begin
            block.qp <= qp;
        end
    end

    // one cycle pulse once the block is complete
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_valid <= 1'b0;
        end else begin
            block_valid <= last_beat;
        end
    end

    // ============================================================
    // checks
    // ============================================================

    // qp outside 0..29 has no mf table entry downstream
    qp_in_range_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        first_beat |-> (qp <= `INTRA_QP_MAX)
    ) else $error("block_collector: qp %0d above limit on first beat", qp);

endmodule

`default_nettype wire

// File: transform/coef_transform.sv
`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module coef_transform (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             block_valid,
    input  wire intra_pkg::residual_block_t block,
    output logic                            coef_valid,
    output intra_pkg::coef_beat_t           coef
);

    // ============================================================
    // control
    // ============================================================

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t                     state;
    intra_pkg::coef_idx_t       idx;
    intra_pkg::residual_block_t blk;
    intra_pkg::coef_t           coef_sum;
    logic                       last_idx;
    logic                       take_block;

    assign last_idx = (idx == intra_pkg::coef_idx_t'(`INTRA_BLOCK_PIXELS - 1));

    // accept in idle, or straight after the final coefficient
    assign take_block = block_valid && ((state == S_IDLE) || last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (take_block) begin
                        state <= S_RUN;
                        idx   <= '0;
                    end
                end
                S_RUN: begin
                    // wraps to 0 after index 15
                    idx <= idx + 1'b1;
                    if (last_idx && !take_block) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                    idx   <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_block) begin
            blk <= block;
        end
    end

    // ============================================================
    // forward transform
    // ============================================================

    // sign rows ++++ ++-- +--+ +-+- as a negate flag
    // sel picks the row, n is the position along it
    function automatic logic neg_weight(input logic [1:0] sel, input logic [1:0] n);
        return (sel[0] & n[1]) ^ (sel[1] & (n[1] ^ n[0]));
    endfunction

    // coefficient 4u+v, weight hu(row) * hv(col) per residual
    always_comb begin
        coef_sum = '0;
        for (int i = 0; i < `INTRA_BLOCK_PIXELS; i++) begin : sum_loop
            intra_pkg::coef_idx_t pos;
            logic                 neg;
            pos = intra_pkg::coef_idx_t'(i);
            neg = neg_weight(idx[3:2], pos[3:2]) ^ neg_weight(idx[1:0], pos[1:0]);
            if (neg) begin
                coef_sum = coef_sum - intra_pkg::coef_t'(blk.res[i]);
            end else begin
                coef_sum = coef_sum + intra_pkg::coef_t'(blk.res[i]);
            end
        end
    end

    assign coef_valid = (state == S_RUN);

    // qp rides along so back to back blocks keep their own
    always_comb begin
        coef.value = coef_sum;
        coef.idx   = idx;
        coef.qp    = blk.qp;
    end

    // ============================================================
    // checks
    // ============================================================

    // input faster than one beat per cycle would land mid block
    no_overlap_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        block_valid |-> ((state == S_IDLE) || last_idx)
    ) else $error("coef_transform: block_valid at index %0d while running", idx);

endmodule

`default_nettype wire

// File: quant/quantizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "intra_config.svh"

module quantizer (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        coef_valid,
    input  wire intra_pkg::coef_beat_t coef,
    output logic                       out_valid,
    output intra_pkg::level_t          out_value
);

    // ============================================================
    // qp split
    // ============================================================

    intra_pkg::qp_t    qp_div;
    intra_pkg::qp_t    qp_mod;
    logic [4:0]        qbits;
    logic [31:0]       f_round;

    assign qp_div = coef.qp / 5'd6;
    assign qp_mod = coef.qp % 5'd6;

    assign qbits = 5'(`INTRA_QBITS_BASE) + qp_div;

    // floor(2^qbits / 3) is the bit pattern ...010101 below qbits
    assign f_round = 32'h5555_5555 >> (6'd32 - {1'b0, qbits});

    // ============================================================
    // multiplier factor
    // ============================================================

    logic [13:0] mf_a;
    logic [13:0] mf_b;
    logic [13:0] mf_c;
    logic [13:0] mf;

    always_comb begin
        case (qp_mod)
            5'd0: begin
                mf_a = 14'd13107;
                mf_b = 14'd5243;
                mf_c = 14'd8066;
            end
            5'd1: begin
                mf_a = 14'd11916;
                mf_b = 14'd4660;
                mf_c = 14'd7490;
            end
            5'd2: begin
                mf_a = 14'd10082;
                mf_b = 14'd4194;
                mf_c = 14'd6554;
            end
            5'd3: begin
                mf_a = 14'd9362;
                mf_b = 14'd3647;
                mf_c = 14'd5825;
            end
            5'd4: begin
                mf_a = 14'd8192;
                mf_b = 14'd3355;
                mf_c = 14'd5243;
            end
            default: begin
                mf_a = 14'd7282;
                mf_b = 14'd2893;
                mf_c = 14'd4559;
            end
        endcase
    end

    // a is even row and even col, b is odd and odd
    always_comb begin
        case (coef.idx)
            4'd0, 4'd2, 4'd8, 4'd10:  mf = mf_a;
            4'd5, 4'd7, 4'd13, 4'd15: mf = mf_b;
            default:                  mf = mf_c;
        endcase
    end

    // ============================================================
    // scale, round, sign
    // ============================================================

    logic              neg;
    logic [12:0]       mag;
    logic [31:0]       scaled;
    logic [31:0]       z_mag;
    intra_pkg::level_t level;

    assign neg    = coef.value[12];
    assign mag    = neg ? 13'(-coef.value) : 13'(coef.value);
    assign scaled = 32'(mag) * 32'(mf);
    assign z_mag  = (scaled + f_round) >> qbits;
    assign level  = neg ? -intra_pkg::level_t'(z_mag) : intra_pkg::level_t'(z_mag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_value <= '0;
        end else begin
            out_valid <= coef_valid;
            out_value <= coef_valid ? level : '0;
        end
    end

    // ============================================================
    // checks
    // ============================================================

    // within a block indices step by one and qp stays fixed
    beat_order_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (coef_valid && coef.idx != '0) |->
            ($past(coef_valid) && coef.idx == $past(coef.idx) + 1'b1 &&
             coef.qp == $past(coef.qp))
    ) else $error("quantizer: beat %0d out of order or qp changed", coef.idx);

endmodule

`default_nettype wire

// File: logic/intra_block_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module intra_block_encoder (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_valid,
    input  wire intra_pkg::pixel_t pixel,
    input  wire intra_pkg::qp_t    qp,
    output logic                   out_valid,
    output intra_pkg::level_t      out_value
);

    // ============================================================
    // stage links
    // ============================================================

    // collector to transform
    logic                       block_valid;
    intra_pkg::residual_block_t block;

    // transform to quantizer
    logic                       coef_valid;
    intra_pkg::coef_beat_t      coef;

    // ============================================================
    // stages
    // ============================================================

    block_collector u_block_collector (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .pixel       (pixel),
        .qp          (qp),
        .block_valid (block_valid),
        .block       (block)
    );

    coef_transform u_coef_transform (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_valid (block_valid),
        .block       (block),
        .coef_valid  (coef_valid),
        .coef        (coef)
    );

    // one cycle latency to the output port
    quantizer u_quantizer (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef_valid (coef_valid),
        .coef       (coef),
        .out_valid  (out_valid),
        .out_value  (out_value)
    );

endmodule

`default_nettype wire

// File: tests/tb_intra_block_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module tb_intra_block_encoder;

    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_CYCLES   = 20;
    localparam int RANDOM_BLOCKS = 20;
    localparam int BURST_BLOCKS  = 4;
    localparam int TOTAL_BLOCKS  = 1 + 4 + RANDOM_BLOCKS + BURST_BLOCKS;
    localparam int WATCHDOG_CYCLES = 2 * (TOTAL_BLOCKS * 20 + RESET_CYCLES);
    localparam int RESULT_WAIT   = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    intra_pkg::pixel_t     pixel;
    intra_pkg::qp_t        qp;
    logic                  out_valid;
    intra_pkg::level_t     out_value;

    int seed;
    int cycle_cnt = 0;
    int last_beat_cyc;
    logic [7:0] blk_pix [16];
    int exp_q[$];
    int got_q[$];
    int got_cyc[$];

    // sign rows h0..h3
    int h_row [4][4] = '{'{1, 1, 1, 1}, '{1, 1, -1, -1}, '{1, -1, -1, 1}, '{1, -1, 1, -1}};
    int mf_a [6] = '{13107, 11916, 10082, 9362, 8192, 7282};
    int mf_b [6] = '{5243, 4660, 4194, 3647, 3355, 2893};
    int mf_c [6] = '{8066, 7490, 6554, 5825, 5243, 4559};

    intra_block_encoder u_intra_block_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pixel     (pixel),
        .qp        (qp),
        .out_valid (out_valid),
        .out_value (out_value)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // outputs are sampled mid cycle, away from the driving edge
    always @(negedge clk) begin
        cycle_cnt++;
        if (rst_n && out_valid) begin
            got_q.push_back(out_value);
            got_cyc.push_back(cycle_cnt);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // ============================================================
    // reference model
    // ============================================================

    function automatic int model_level(input int k, input int qp_val);
        int coef;
        int mag;
        int mf;
        int qbits;
        int z;
        coef = 0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                coef += h_row[k / 4][r] * h_row[k % 4][c] * (int'(blk_pix[4 * r + c]) - 128);
            end
        end
        if (k == 0 || k == 2 || k == 8 || k == 10) begin
            mf = mf_a[qp_val % 6];
        end else if (k == 5 || k == 7 || k == 13 || k == 15) begin
            mf = mf_b[qp_val % 6];
        end else begin
            mf = mf_c[qp_val % 6];
        end
        qbits = 15 + qp_val / 6;
        mag = (coef < 0) ? -coef : coef;
        z = (mag * mf + (1 << qbits) / 3) >> qbits;
        return (coef < 0) ? -z : z;
    endfunction

    // ============================================================
    // drivers and checkers
    // ============================================================

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic clear_queues();
        exp_q.delete();
        got_q.delete();
        got_cyc.delete();
    endtask

    task automatic fill_flat(input logic [7:0] value);
        for (int i = 0; i < 16; i++) begin
            blk_pix[i] = value;
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < 16; i++) begin
            blk_pix[i] = $random(seed) & 8'hff;
        end
    endtask

    // qp only counts on beat 0, later beats carry junk qp
    task automatic send_block(input int qp_val, input bit with_gaps);
        int gaps_left;
        gaps_left = 4;
        for (int k = 0; k < 16; k++) begin
            exp_q.push_back(model_level(k, qp_val));
        end
        for (int i = 0; i < 16; i++) begin
            if (with_gaps && i > 0 && gaps_left > 0 && ($random(seed) & 3) == 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
                gaps_left--;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            pixel    <= blk_pix[i];
            qp       <= (i == 0) ? qp_val : $unsigned($random(seed)) % 30;
        end
        last_beat_cyc = cycle_cnt + 1;
    endtask

    task automatic idle_input();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic collect_and_compare(input string test_name);
        int waited;
        waited = 0;
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
            waited++;
            if (waited > RESULT_WAIT) begin
                $display("%s: only %0d of %0d levels arrived", test_name, got_q.size(),
                         exp_q.size());
                abort_run();
            end
        end
        // extra levels would show up here
        repeat (4) @(posedge clk);
        assert (got_q.size() == exp_q.size()) else begin
            $display("%s: %0d levels seen, %0d expected", test_name, got_q.size(), exp_q.size());
            abort_run();
        end
        for (int i = 0; i < exp_q.size(); i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("Fail at %0t: out_value level %0d in %s, expected %0d, got %0d",
                         $time, i, test_name, exp_q[i], got_q[i]);
                abort_run();
            end
        end
    endtask

    task automatic check_no_gap(input string test_name);
        for (int i = 1; i < got_cyc.size(); i++) begin
            assert (got_cyc[i] == got_cyc[0] + i) else begin
                $display("Fail at %0t: out_valid in %s, expected cycle %0d, got cycle %0d",
                         $time, test_name, got_cyc[0] + i, got_cyc[i]);
                abort_run();
            end
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic test_idle_outputs();
        clear_queues();
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            assert (out_valid == 1'b0) else begin
                $display("Fail at %0t: out_valid expected 0, got %0b", $time, out_valid);
                abort_run();
            end
            assert (out_value == 0) else begin
                $display("Fail at %0t: out_value expected 0, got %0d", $time, out_value);
                abort_run();
            end
        end
    endtask

    task automatic test_dc_block();
        clear_queues();
        fill_flat(8'd128);
        send_block(0, 1'b0);
        idle_input();
        collect_and_compare("dc block");
        // edge E+2 is three edges after the one driving beat 15
        assert (got_cyc[0] == last_beat_cyc + 3) else begin
            $display("Fail at %0t: out_valid rise cycle expected %0d, got %0d",
                     $time, last_beat_cyc + 3, got_cyc[0]);
            abort_run();
        end
        check_no_gap("dc block");
    endtask

    task automatic test_flat_extremes();
        logic [7:0] values [2];
        int qps [2];
        values = '{8'd255, 8'd0};
        qps = '{0, 29};
        foreach (values[v]) begin
            foreach (qps[q]) begin
                clear_queues();
                fill_flat(values[v]);
                send_block(qps[q], 1'b0);
                idle_input();
                collect_and_compare("flat block");
            end
        end
    endtask

    task automatic test_random_blocks();
        clear_queues();
        for (int b = 0; b < RANDOM_BLOCKS; b++) begin
            fill_random();
            send_block($unsigned($random(seed)) % 30, b % 2 == 1);
        end
        idle_input();
        collect_and_compare("random blocks");
    endtask

    task automatic test_back_to_back();
        clear_queues();
        for (int b = 0; b < BURST_BLOCKS; b++) begin
            fill_random();
            send_block((b * 11 + 3) % 30, 1'b0);
        end
        idle_input();
        collect_and_compare("back to back");
        check_no_gap("back to back");
    endtask

    initial begin
        seed     = 32'h5221eff7;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        pixel    = '0;
        qp       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        test_idle_outputs();
        test_dc_block();
        test_flat_extremes();
        test_random_blocks();
        test_back_to_back();

        repeat (2) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/intra_pkg.sv
logic/block_collector.sv
transform/coef_transform.sv
quant/quantizer.sv
logic/intra_block_encoder.sv
tests/tb_intra_block_encoder.sv
